// ==== logic/arp_dma_pkg.sv ====
`default_nettype none

package arp_dma_pkg;

   localparam int data_w = 128;
   localparam int keep_w = data_w / 8;

   // ARP ethertype as it reads in wire order from bytes 12 and 13
   localparam logic [15:0] arp_ethertype = 16'h0806;
   localparam logic [7:0]  dma_port      = 8'hFF;
   localparam logic [31:0] meta_magic    = 32'hA5A5A5A5;
   localparam logic [15:0] meta_bytes    = 16'd16;

   // Side-band word with pkt_len in the low half
   typedef struct packed {
      logic [7:0]  dst_port;
      logic [7:0]  src_port;
      logic [15:0] pkt_len;
   } user_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [keep_w-1:0] keep;
      user_t             user;
      logic              last;
   } beat_t;

   // Two readings of one data word with byte 0 at the bottom
   typedef union packed {
      logic [data_w-1:0] raw;
      struct packed {
         logic [15:0] pad;
         logic [15:0] ethertype;
         logic [47:0] src_mac;
         logic [47:0] dst_mac;
      } eth;
      struct packed {
         logic [31:0] count;
         logic [31:0] offset;
         logic [31:0] size;
         logic [31:0] magic;
      } meta;
   } beat_view_u;

   // Keep masks are contiguous from byte 0, so the highest set bit gives the count
   function automatic logic [4:0] keep_bytes(input logic [keep_w-1:0] keep);
      logic [4:0] n;
      n = '0;
      for (int i = 0; i < keep_w; i++) begin
         if (keep[i]) begin
            n = 5'(i + 1);
         end
      end
      return n;
   endfunction

endpackage

`default_nettype wire

// ==== logic/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
   parameter int DATA_W     = arp_dma_pkg::data_w,
   parameter int DEPTH_BITS = 3
) (
   input  wire logic                axis_aclk,
   input  wire logic                axis_resetn,
   input  wire arp_dma_pkg::beat_t  din,
   input  wire logic                wr_en,
   input  wire logic                rd_en,
   output arp_dma_pkg::beat_t       dout,
   output logic                     empty,
   output logic                     nearly_full
);

   localparam int depth     = 1 << DEPTH_BITS;
   localparam int keep_bits = DATA_W / 8;

   logic [DATA_W-1:0]     mem_data [depth];
   logic [keep_bits-1:0]  mem_keep [depth];
   arp_dma_pkg::user_t    mem_user [depth];
   logic                  mem_last [depth];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   // Requests on a full or empty buffer are ignored
   assign do_wr = wr_en && (count != (DEPTH_BITS+1)'(depth));
   assign do_rd = rd_en && !empty;

   assign empty       = (count == '0);
   assign nearly_full = (count >= (DEPTH_BITS+1)'(depth - 2));

   always_ff @(posedge axis_aclk) begin
      if (do_wr) begin
         mem_data[wr_ptr] <= din.data;
         mem_keep[wr_ptr] <= din.keep;
         mem_user[wr_ptr] <= din.user;
         mem_last[wr_ptr] <= din.last;
      end
   end

   // Head beat shown straight from the array
   always_comb begin
      dout.data = mem_data[rd_ptr];
      dout.keep = mem_keep[rd_ptr];
      dout.user = mem_user[rd_ptr];
      dout.last = mem_last[rd_ptr];
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/dma_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_store #(
   parameter int DEPTH_BITS = 4
) (
   input  wire logic                axis_aclk,
   input  wire logic                axis_resetn,
   input  wire arp_dma_pkg::beat_t  din,
   input  wire logic                wr_en,
   input  wire logic                rd_en,
   output arp_dma_pkg::beat_t       head,
   output logic                     loaded,
   output logic [15:0]              byte_total
);

   // Beat storage for one DMA packet
   stream_fifo #(
      .DEPTH_BITS  (DEPTH_BITS)
   ) buf_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .din         (din),
      .wr_en       (wr_en),
      .rd_en       (rd_en),
      .dout        (head),
      .empty       (),
      .nearly_full ()
   );

   // Loaded once the whole packet is in, freed when its last beat leaves
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         loaded     <= 1'b0;
         byte_total <= '0;
      end else if (rd_en && head.last) begin
         loaded     <= 1'b0;
         byte_total <= '0;
      end else if (wr_en) begin
         byte_total <= byte_total + 16'(arp_dma_pkg::keep_bytes(din.keep));
         if (din.last) begin
            loaded <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/meta_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module meta_builder (
   input  wire logic                        axis_aclk,
   input  wire logic                        axis_resetn,
   input  wire logic [31:0]                 transfer_size,
   input  wire logic [15:0]                 byte_total,
   input  wire logic [15:0]                 arp_len,
   input  wire logic                        advance,
   output logic [arp_dma_pkg::data_w-1:0]   meta_beat,
   output logic [15:0]                      aug_len
);

   logic [31:0]             offset;
   arp_dma_pkg::beat_view_u meta_view;

   // Running total of DMA bytes already sent downstream
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         offset <= '0;
      end else if (advance) begin
         offset <= offset + 32'(byte_total);
      end
   end

   always_comb begin
      meta_view.meta.magic  = arp_dma_pkg::meta_magic;
      meta_view.meta.size   = transfer_size;
      meta_view.meta.offset = offset;
      meta_view.meta.count  = 32'(byte_total);
   end

   assign meta_beat = meta_view.raw;

   // ARP bytes, then the metadata beat, then the buffered payload
   assign aug_len = arp_len + arp_dma_pkg::meta_bytes + byte_total;

endmodule

`default_nettype wire

// ==== logic/flow_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module flow_ctrl (
   input  wire logic                          axis_aclk,
   input  wire logic                          axis_resetn,
   input  wire arp_dma_pkg::beat_t            in_head,
   input  wire logic                          in_empty,
   output logic                               in_rd_en,
   output logic                               dma_wr_en,
   input  wire arp_dma_pkg::beat_t            dma_head,
   input  wire logic                          dma_loaded,
   output logic                               dma_rd_en,
   input  wire logic [arp_dma_pkg::data_w-1:0] meta_beat,
   input  wire logic [15:0]                   aug_len,
   output logic                               advance,
   output arp_dma_pkg::beat_t                 m_axis,
   output logic                               m_axis_tvalid,
   input  wire logic                          m_axis_tready
);

   localparam logic [2:0] st_idle     = 3'd0;
   localparam logic [2:0] st_pass     = 3'd1;
   localparam logic [2:0] st_arp_body = 3'd2;
   localparam logic [2:0] st_meta     = 3'd3;
   localparam logic [2:0] st_dma_out  = 3'd4;
   localparam logic [2:0] st_dma_in   = 3'd5;
   localparam logic [2:0] st_drop     = 3'd6;

   logic [2:0]              state;
   logic [2:0]              state_next;
   arp_dma_pkg::beat_view_u head_view;
   arp_dma_pkg::beat_t      out_next;
   logic                    out_load;
   logic                    out_free;
   logic                    is_dma;
   logic                    is_arp;

   assign head_view = in_head.data;
   assign is_dma    = (in_head.user.src_port == arp_dma_pkg::dma_port);

   // Ethertype bytes land swapped in the little-endian word
   assign is_arp = ({head_view.eth.ethertype[7:0], head_view.eth.ethertype[15:8]}
                    == arp_dma_pkg::arp_ethertype);

   // Output register can take a beat when empty or draining this cycle
   assign out_free = !m_axis_tvalid || m_axis_tready;

   always_comb begin
      state_next = state;
      in_rd_en   = 1'b0;
      dma_wr_en  = 1'b0;
      dma_rd_en  = 1'b0;
      advance    = 1'b0;
      out_load   = 1'b0;
      out_next   = in_head;
      case (state)
         st_idle: begin
            if (!in_empty) begin
               if (is_dma) begin
                  // Never waits on the output side
                  in_rd_en  = 1'b1;
                  dma_wr_en = !dma_loaded;
                  if (!in_head.last) begin
                     state_next = dma_loaded ? st_drop : st_dma_in;
                  end
               end else if (is_arp && dma_loaded) begin
                  if (out_free) begin
                     in_rd_en              = 1'b1;
                     out_load              = 1'b1;
                     out_next.user.pkt_len = aug_len;
                     out_next.last         = 1'b0;
                     state_next = in_head.last ? st_meta : st_arp_body;
                  end
               end else if (out_free) begin
                  in_rd_en = 1'b1;
                  out_load = 1'b1;
                  if (!in_head.last) begin
                     state_next = st_pass;
                  end
               end
            end
         end
         st_pass: begin
            if (!in_empty && out_free) begin
               in_rd_en = 1'b1;
               out_load = 1'b1;
               if (in_head.last) begin
                  state_next = st_idle;
               end
            end
         end
         st_arp_body: begin
            if (!in_empty && out_free) begin
               in_rd_en      = 1'b1;
               out_load      = 1'b1;
               out_next.last = 1'b0;
               if (in_head.last) begin
                  state_next = st_meta;
               end
            end
         end
         st_meta: begin
            if (out_free) begin
               out_load      = 1'b1;
               out_next.data = meta_beat;
               out_next.keep = '1;
               // Same side-band word as the ARP beat still in the register
               out_next.user = m_axis.user;
               out_next.last = 1'b0;
               state_next    = st_dma_out;
            end
         end
         st_dma_out: begin
            if (out_free) begin
               dma_rd_en = 1'b1;
               out_load  = 1'b1;
               out_next  = dma_head;
               if (dma_head.last) begin
                  advance    = 1'b1;
                  state_next = st_idle;
               end
            end
         end
         st_dma_in: begin
            if (!in_empty) begin
               in_rd_en  = 1'b1;
               dma_wr_en = 1'b1;
               if (in_head.last) begin
                  state_next = st_idle;
               end
            end
         end
         st_drop: begin
            if (!in_empty) begin
               in_rd_en = 1'b1;
               if (in_head.last) begin
                  state_next = st_idle;
               end
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         state         <= st_idle;
         m_axis_tvalid <= 1'b0;
      end else begin
         state <= state_next;
         if (out_load) begin
            m_axis_tvalid <= 1'b1;
         end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
         end
      end
   end

   // Holds its beat until accepted
   always_ff @(posedge axis_aclk) begin
      if (out_load) begin
         m_axis <= out_next;
      end
   end

endmodule

`default_nettype wire

// ==== logic/arp_dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arp_dma_top #(
   parameter int DATA_W          = arp_dma_pkg::data_w,
   parameter int FIFO_DEPTH_BITS = 3,
   parameter int DMA_DEPTH_BITS  = 4
) (
   input  wire logic                axis_aclk,
   input  wire logic                axis_resetn,
   input  wire arp_dma_pkg::beat_t  s_axis,
   input  wire logic                s_axis_tvalid,
   output logic                     s_axis_tready,
   output arp_dma_pkg::beat_t       m_axis,
   output logic                     m_axis_tvalid,
   input  wire logic                m_axis_tready,
   input  wire logic [31:0]         transfer_size
);

   arp_dma_pkg::beat_t             in_head;
   logic                           in_empty;
   logic                           in_nearly_full;
   logic                           in_rd_en;
   logic                           dma_wr_en;
   logic                           dma_rd_en;
   arp_dma_pkg::beat_t             dma_head;
   logic                           dma_loaded;
   logic [15:0]                    byte_total;
   logic [arp_dma_pkg::data_w-1:0] meta_beat;
   logic [15:0]                    aug_len;
   logic                           advance;

   assign s_axis_tready = !in_nearly_full;

   stream_fifo #(
      .DATA_W      (DATA_W),
      .DEPTH_BITS  (FIFO_DEPTH_BITS)
   ) ingress_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .din         (s_axis),
      .wr_en       (s_axis_tvalid && s_axis_tready),
      .rd_en       (in_rd_en),
      .dout        (in_head),
      .empty       (in_empty),
      .nearly_full (in_nearly_full)
   );

   // DMA beats are copied from the ingress head
   dma_store #(
      .DEPTH_BITS  (DMA_DEPTH_BITS)
   ) dma_store_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .din         (in_head),
      .wr_en       (dma_wr_en),
      .rd_en       (dma_rd_en),
      .head        (dma_head),
      .loaded      (dma_loaded),
      .byte_total  (byte_total)
   );

   meta_builder meta_builder_i (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .transfer_size (transfer_size),
      .byte_total    (byte_total),
      .arp_len       (in_head.user.pkt_len),
      .advance       (advance),
      .meta_beat     (meta_beat),
      .aug_len       (aug_len)
   );

   flow_ctrl flow_ctrl_i (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .in_head       (in_head),
      .in_empty      (in_empty),
      .in_rd_en      (in_rd_en),
      .dma_wr_en     (dma_wr_en),
      .dma_head      (dma_head),
      .dma_loaded    (dma_loaded),
      .dma_rd_en     (dma_rd_en),
      .meta_beat     (meta_beat),
      .aug_len       (aug_len),
      .advance       (advance),
      .m_axis        (m_axis),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

endmodule

`default_nettype wire

// ==== dv/tb_arp_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_arp_dma;

   localparam int rec_words  = 5;
   localparam int max_words  = 512;
   localparam int wait_limit = 200;
   localparam int stall_from = 6;
   localparam int stall_to   = 30;

   logic               axis_aclk;
   logic               axis_resetn;
   arp_dma_pkg::beat_t s_axis;
   logic               s_axis_tvalid;
   logic               s_axis_tready;
   arp_dma_pkg::beat_t m_axis;
   logic               m_axis_tvalid;
   logic               m_axis_tready;
   logic [31:0]        transfer_size;

   logic [127:0]       vec_mem [max_words];
   arp_dma_pkg::beat_t in_q[$];
   arp_dma_pkg::beat_t exp_q[$];
   int                 n_expected;
   int                 n_checked;
   logic [31:0]        gap_rnd;
   logic [31:0]        ready_rnd;
   logic               ready_dropped;

   arp_dma_top arp_dma_top_i (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .s_axis        (s_axis),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis        (m_axis),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .transfer_size (transfer_size)
   );

   always #2 axis_aclk = ~axis_aclk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [127:0] got,
                                  input logic [127:0] exp, input int idx);
      $display("** Error at time %0t: %s of output beat %0d is %h, expected %h",
               $time, name, idx, got, exp);
      abort_run("output stream differs from the expected stream");
   endtask

   // Records of five words in the order tag, last, user, keep, data
   task automatic load_vectors;
      logic [3:0]         tag;
      arp_dma_pkg::beat_t b;
      for (int i = 0; i < max_words; i++) begin
         vec_mem[i] = '0;
      end
      $readmemh("dv/arp_dma_vectors.hex", vec_mem);
      for (int r = 0; r + rec_words <= max_words; r += rec_words) begin
         tag    = vec_mem[r][3:0];
         b.last = vec_mem[r+1][0];
         b.user = vec_mem[r+2][31:0];
         b.keep = vec_mem[r+3][15:0];
         b.data = vec_mem[r+4];
         if (tag == 4'h1) begin
            transfer_size = vec_mem[r+4][31:0];
         end else if (tag == 4'h2) begin
            in_q.push_back(b);
         end else if (tag == 4'h3) begin
            exp_q.push_back(b);
         end
      end
      n_expected = exp_q.size();
      assert (in_q.size() > 0 && n_expected > 0) else begin
         abort_run("vectors file holds no input or expected beats");
      end
   endtask

   // Entered and left on a falling edge
   task automatic send_beat(input arp_dma_pkg::beat_t b, input int idx);
      int waited;
      waited        = 0;
      s_axis        = b;
      s_axis_tvalid = 1'b1;
      // tready only moves on the rising edge
      while (!s_axis_tready) begin
         @(negedge axis_aclk);
         waited++;
         assert (waited <= wait_limit) else begin
            abort_run($sformatf("input beat %0d was never accepted", idx));
         end
      end
      @(negedge axis_aclk);
      s_axis_tvalid = 1'b0;
   endtask

   task automatic drive_inputs;
      arp_dma_pkg::beat_t b;
      int                 idx;
      idx = 0;
      while (in_q.size() > 0) begin
         b       = in_q.pop_front();
         gap_rnd = xorshift(gap_rnd);
         if (gap_rnd[1:0] == 2'b00) begin
            @(negedge axis_aclk);
         end
         send_beat(b, idx);
         idx++;
      end
   endtask

   task automatic compare_beat(input arp_dma_pkg::beat_t exp, input int idx);
      assert (m_axis.data === exp.data) else begin
         report_mismatch("m_axis.data", m_axis.data, exp.data, idx);
      end
      assert (m_axis.keep === exp.keep) else begin
         report_mismatch("m_axis.keep", 128'(m_axis.keep), 128'(exp.keep), idx);
      end
      assert (m_axis.user === exp.user) else begin
         report_mismatch("m_axis.user", 128'(m_axis.user), 128'(exp.user), idx);
      end
      assert (m_axis.last === exp.last) else begin
         report_mismatch("m_axis.last", 128'(m_axis.last), 128'(exp.last), idx);
      end
   endtask

   // Ready is set on the falling edge, so valid and ready here decide the next rising edge
   task automatic collect_outputs;
      arp_dma_pkg::beat_t exp;
      int                 waited;
      int                 cyc;
      cyc = 0;
      while (exp_q.size() > 0) begin
         exp    = exp_q.pop_front();
         waited = 0;
         do begin
            @(negedge axis_aclk);
            cyc++;
            waited++;
            ready_rnd = xorshift(ready_rnd);
            // Long stall early on to fill the ingress FIFO
            if (cyc >= stall_from && cyc < stall_to) begin
               m_axis_tready = 1'b0;
            end else begin
               m_axis_tready = (ready_rnd[1:0] != 2'b00);
            end
            if (!s_axis_tready) begin
               ready_dropped = 1'b1;
            end
            assert (waited <= wait_limit) else begin
               abort_run($sformatf("output beat %0d never arrived", n_checked));
            end
         end while (!(m_axis_tvalid && m_axis_tready));
         compare_beat(exp, n_checked);
         n_checked++;
      end
      // Nothing may follow the last expected beat
      m_axis_tready = 1'b1;
      repeat (20) begin
         @(negedge axis_aclk);
         assert (!m_axis_tvalid) else begin
            abort_run("DUT sent an output beat beyond the expected stream");
         end
      end
   endtask

   initial begin
      axis_aclk     = 1'b0;
      axis_resetn   = 1'b0;
      s_axis        = '0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      transfer_size = '0;
      n_checked     = 0;
      gap_rnd       = 32'h974f;
      ready_rnd     = xorshift(32'h974f);
      ready_dropped = 1'b0;
      load_vectors();
      repeat (2) @(posedge axis_aclk);
      @(negedge axis_aclk);
      axis_resetn = 1'b1;
      fork
         drive_inputs();
         collect_outputs();
      join
      assert (ready_dropped) else begin
         abort_run("s_axis_tready never dropped under output stalls");
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/arp_dma_vectors.hex ====
// Columns: tag (1 size, 2 input beat, 3 expected output beat), last, user, keep, data
// user is dst_port src_port pkt_len, data byte 0 at the right
1 0 00000000 0000 00000000000000000000000000001000
// Plain IPv4 packet, two beats
2 0 01020014 ffff 00000008a1a2a3a4a5a6b1b2b3b4b5b6
2 1 01020014 000f 000000000000000000000000c3c2c1c0
3 0 01020014 ffff 00000008a1a2a3a4a5a6b1b2b3b4b5b6
3 1 01020014 000f 000000000000000000000000c3c2c1c0
// ARP with the buffer empty
2 1 03040010 ffff 00000608c1c2c3c4c5c6d1d2d3d4d5d6
3 1 03040010 ffff 00000608c1c2c3c4c5c6d1d2d3d4d5d6
// DMA of 20 bytes, then ARP of 28 bytes
2 0 00ff0014 ffff 0f0e0d0c0b0a09080706050403020100
2 1 00ff0014 000f 00000000000000000000000013121110
2 0 0506001c ffff 00000608e1e2e3e4e5e6f1f2f3f4f5f6
2 1 0506001c 0fff 000000002b2a29282726252423222120
3 0 05060040 ffff 00000608e1e2e3e4e5e6f1f2f3f4f5f6
3 0 0506001c 0fff 000000002b2a29282726252423222120
3 0 0506001c ffff 000000140000000000001000a5a5a5a5
3 0 00ff0014 ffff 0f0e0d0c0b0a09080706050403020100
3 1 00ff0014 000f 00000000000000000000000013121110
// DMA of 10 bytes, ARP at offset 20
2 1 07ff000a 03ff 00000000000039383736353433323130
2 1 08090010 ffff 00000608a1b2c3d4e5f6a7b8c9d0e1f2
3 0 0809002a ffff 00000608a1b2c3d4e5f6a7b8c9d0e1f2
3 0 0809002a ffff 0000000a0000001400001000a5a5a5a5
3 1 07ff000a 03ff 00000000000039383736353433323130
// DMA of 8 bytes kept, second DMA dropped
2 1 00ff0008 00ff 00000000000000004746454443424140
2 0 11ff0012 ffff 5f5e5d5c5b5a59585756555453525150
2 1 11ff0012 0003 00000000000000000000000000006160
2 0 0a0b0028 ffff 00000008111213141516212223242526
2 0 0a0b0028 ffff 7f7e7d7c7b7a79787776757473727170
2 1 0a0b0028 00ff 00000000000000008786858483828180
3 0 0a0b0028 ffff 00000008111213141516212223242526
3 0 0a0b0028 ffff 7f7e7d7c7b7a79787776757473727170
3 1 0a0b0028 00ff 00000000000000008786858483828180
// ARP at offset 30 carries the first kept payload
2 1 0c0d0010 ffff 00000608313233343536414243444546
3 0 0c0d0028 ffff 00000608313233343536414243444546
3 0 0c0d0028 ffff 000000080000001e00001000a5a5a5a5
3 1 00ff0008 00ff 00000000000000004746454443424140
// Buffer empty again
2 1 0e0f0010 ffff 00000608919293949596a1a2a3a4a5a6
3 1 0e0f0010 ffff 00000608919293949596a1a2a3a4a5a6

// ==== build.f ====
logic/arp_dma_pkg.sv
logic/stream_fifo.sv
logic/dma_store.sv
logic/meta_builder.sv
logic/flow_ctrl.sv
logic/arp_dma_top.sv
dv/tb_arp_dma.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f build.f --top-module tb_arp_dma -Mdir obj_dir -o tb_arp_dma
	./obj_dir/tb_arp_dma | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
